// ==== src/ln_pkg.sv ====
package ln_pkg;

    // sample geometry
    localparam int LN_DEPTH      = 8;
    localparam int LN_DEPTH_LOG2 = 3;
    // fractional bits of elements, gamma and beta (Q3.4)
    localparam int LN_FRAC       = 4;

    // config bus
    localparam int LN_REG_ADDR_W = 4;
    localparam int LN_CTRL_W     = 16;

    // saturation bounds of the output element
    localparam int LN_ELEM_MAX   = 127;
    localparam int LN_ELEM_MIN   = -128;

    // element and statistic widths
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [10:0] sum_t;
    typedef logic        [17:0] sumsq_t;
    // raw square scale, 8 fractional bits
    typedef logic        [15:0] var_t;
    typedef logic        [7:0]  std_t;
    typedef logic signed [8:0]  cen_t;

    typedef logic [LN_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [LN_CTRL_W-1:0]     ctrl_t;

    // 1.0 in Q3.4, gamma reset value
    localparam elem_t LN_GAMMA_ONE = elem_t'(1 << LN_FRAC);

    // register map: 0..7 gamma lanes, 8..14 beta lanes 0..6
    // top address is the control register and shadows beta lane 7
    // each write to it shifts one byte in, epsilon first, then the enable byte
    localparam reg_addr_t LN_ADDR_BETA0 = reg_addr_t'(LN_DEPTH);
    localparam reg_addr_t LN_ADDR_CTRL  = '1;

    typedef struct packed {
        elem_t [LN_DEPTH-1:0] lane;
    } ln_vec_t;

    typedef struct packed {
        cen_t [LN_DEPTH-1:0] lane;
    } ln_cen_vec_t;

    typedef struct packed {
        elem_t mean;
        var_t  variance;
    } ln_stats_t;

    typedef struct packed {
        logic    enable;
        var_t    epsilon;
        ln_vec_t gamma;
        ln_vec_t beta;
    } ln_affine_t;

endpackage

// ==== src/ln_affine_regs.sv ====
`timescale 1ns/10ps

module ln_affine_regs
    import ln_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       cfg_we_i,
    input  reg_addr_t  cfg_addr_i,
    input  elem_t      cfg_wdata_i,
    output ln_affine_t affine_o
);

    ln_vec_t gamma_q;
    ln_vec_t beta_q;
    // bit 0 enable, bits 15:8 epsilon
    ctrl_t   ctrl_q;
    logic [LN_DEPTH_LOG2-1:0] lane_sel;
    logic    is_ctrl;
    logic    is_beta;

    // low address bits pick the lane
    assign lane_sel = cfg_addr_i[LN_DEPTH_LOG2-1:0];
    assign is_ctrl  = (cfg_addr_i == LN_ADDR_CTRL);
    // upper half of the map is beta
    assign is_beta  = (cfg_addr_i >= LN_ADDR_BETA0);

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            // identity affine: gamma 1.0, beta 0, epsilon 0, disabled
            gamma_q <= {LN_DEPTH{LN_GAMMA_ONE}};
            beta_q  <= '0;
            ctrl_q  <= '0;
        end
        else if (cfg_we_i)
        begin
            // one register per strobe
            if (is_ctrl)
                ctrl_q <= {ctrl_q[7:0], cfg_wdata_i};
            else if (is_beta)
                beta_q.lane[lane_sel] <= cfg_wdata_i;
            else
                gamma_q.lane[lane_sel] <= cfg_wdata_i;
        end
    end

    // epsilon is a plain integer added to the raw variance
    assign affine_o.enable  = ctrl_q[0];
    assign affine_o.epsilon = var_t'(ctrl_q[15:8]);
    assign affine_o.gamma   = gamma_q;
    assign affine_o.beta    = beta_q;

endmodule

// ==== src/ln_moment_stage.sv ====
`timescale 1ns/10ps

module ln_moment_stage
    import ln_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      advance_i,
    input  ln_vec_t   vec_i,
    input  logic      valid_i,
    output ln_vec_t   vec_o,
    output ln_stats_t stats_o,
    output logic      valid_o
);

    sum_t    lane_sum;
    sumsq_t  lane_sumsq;
    // stage 1 registers
    sum_t    sum_q;
    sumsq_t  sumsq_q;
    ln_vec_t vec_s1_q;
    logic    valid_s1_q;
    // stage 2 combinational
    elem_t   mean_d;
    logic signed [19:0] mean_sq;
    logic signed [19:0] var_diff;
    var_t    var_d;
    // stage 2 registers
    ln_vec_t   vec_s2_q;
    ln_stats_t stats_q;
    logic      valid_s2_q;

    // lane sum and sum of squares over the whole sample
    always_comb
    begin
        logic signed [15:0] sq;
        lane_sum   = '0;
        lane_sumsq = '0;
        sq         = '0;
        for (int i = 0; i < LN_DEPTH; i++)
        begin
            sq         = vec_i.lane[i] * vec_i.lane[i];
            lane_sum   = lane_sum + sum_t'(vec_i.lane[i]);
            // square is never negative, zero extend
            lane_sumsq = lane_sumsq + {2'b00, sq};
        end
    end

    // mean floors toward minus infinity
    assign mean_d   = elem_t'(sum_q >>> LN_DEPTH_LOG2);
    assign mean_sq  = mean_d * mean_d;
    assign var_diff = $signed({2'b00, sumsq_q >> LN_DEPTH_LOG2}) - mean_sq;
    // floored mean can push the difference just below zero
    assign var_d    = (var_diff < 0) ? '0 : var_t'(var_diff);

    // valid bits, shift only on advance
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            valid_s1_q <= 1'b0;
            valid_s2_q <= 1'b0;
        end
        else if (advance_i)
        begin
            valid_s1_q <= valid_i;
            valid_s2_q <= valid_s1_q;
        end
    end

    // payload, frozen together with the valid bits
    always_ff @(posedge clk)
    begin
        if (advance_i)
        begin
            sum_q            <= lane_sum;
            sumsq_q          <= lane_sumsq;
            vec_s1_q         <= vec_i;
            stats_q.mean     <= mean_d;
            stats_q.variance <= var_d;
            vec_s2_q         <= vec_s1_q;
        end
    end

    assign vec_o   = vec_s2_q;
    assign stats_o = stats_q;
    assign valid_o = valid_s2_q;

endmodule

// ==== src/ln_isqrt_stage.sv ====
`timescale 1ns/10ps

module ln_isqrt_stage
    import ln_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        advance_i,
    input  ln_vec_t     vec_i,
    input  ln_stats_t   stats_i,
    input  logic        valid_i,
    input  var_t        epsilon_i,
    output ln_cen_vec_t cen_o,
    output std_t        std_o,
    output logic        valid_o
);

    var_t        radicand;
    std_t        root;
    std_t        std_d;
    ln_cen_vec_t cen_d;
    ln_cen_vec_t cen_q;
    std_t        std_q;
    logic        valid_q;

    // restoring square root, one bit pair per step, msb first
    function automatic std_t isqrt(input var_t value);
        logic [17:0] rem;
        logic [17:0] trial;
        std_t        res;
        rem   = '0;
        trial = '0;
        res   = '0;
        for (int i = 7; i >= 0; i--)
        begin
            // bring down the next two bits
            rem   = {rem[15:0], value[2*i +: 2]};
            trial = {8'd0, res, 2'b01};
            if (rem >= trial)
            begin
                rem = rem - trial;
                res = {res[6:0], 1'b1};
            end
            else
            begin
                res = {res[6:0], 1'b0};
            end
        end
        return res;
    endfunction

    // epsilon is at most one byte, no overflow past 16 bits
    assign radicand = stats_i.variance + epsilon_i;
    assign root     = isqrt(radicand);
    // never divide by zero downstream
    assign std_d    = (root == '0) ? std_t'(1) : root;

    // centered lanes, sign extended before the subtract
    always_comb
    begin
        for (int i = 0; i < LN_DEPTH; i++)
        begin
            cen_d.lane[i] = cen_t'(vec_i.lane[i]) - cen_t'(stats_i.mean);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            valid_q <= 1'b0;
        else if (advance_i)
            valid_q <= valid_i;
    end

    always_ff @(posedge clk)
    begin
        if (advance_i)
        begin
            cen_q <= cen_d;
            std_q <= std_d;
        end
    end

    assign cen_o   = cen_q;
    assign std_o   = std_q;
    assign valid_o = valid_q;

endmodule

// ==== src/ln_scale_stage.sv ====
`timescale 1ns/10ps

module ln_scale_stage
    import ln_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  ln_cen_vec_t cen_i,
    input  std_t        std_i,
    input  logic        valid_i,
    input  ln_affine_t  affine_i,
    input  logic        out_ready_i,
    output ln_vec_t     vec_o,
    output logic        valid_o,
    output logic        advance_o
);

    ln_vec_t sat_vec;
    ln_vec_t vec_q;
    logic    valid_q;
    // divisor as a positive signed value
    logic signed [8:0] den;

    assign den = $signed({1'b0, std_i});

    // per lane: divide, optional affine, saturate
    always_comb
    begin
        logic signed [12:0] num;
        logic signed [12:0] quot;
        logic signed [20:0] prod;
        logic signed [21:0] aff;
        logic signed [21:0] res;
        num  = '0;
        quot = '0;
        prod = '0;
        aff  = '0;
        res  = '0;
        for (int i = 0; i < LN_DEPTH; i++)
        begin
            // centered value in Q.4 before the divide
            num  = {cen_i.lane[i], {LN_FRAC{1'b0}}};
            // signed divide truncates toward zero
            quot = num / den;
            prod = quot * affine_i.gamma.lane[i];
            aff  = (prod >>> LN_FRAC) + affine_i.beta.lane[i];
            if (affine_i.enable)
                res = aff;
            else
                res = quot;
            // clamp into the element range
            if (res > LN_ELEM_MAX)
                sat_vec.lane[i] = elem_t'(LN_ELEM_MAX);
            else if (res < LN_ELEM_MIN)
                sat_vec.lane[i] = elem_t'(LN_ELEM_MIN);
            else
                sat_vec.lane[i] = elem_t'(res);
        end
    end

    // whole pipeline moves unless a held output is refused
    assign advance_o = ~valid_q | out_ready_i;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            valid_q <= 1'b0;
        else if (advance_o)
            valid_q <= valid_i;
    end

    // output stays stable while stalled
    always_ff @(posedge clk)
    begin
        if (advance_o)
            vec_q <= sat_vec;
    end

    assign vec_o   = vec_q;
    assign valid_o = valid_q;

endmodule

// ==== src/ln_top.sv ====
`timescale 1ns/10ps

module ln_top
    import ln_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    // config write strobe, no handshake
    input  logic      cfg_we_i,
    input  reg_addr_t cfg_addr_i,
    input  elem_t     cfg_wdata_i,
    // sample input
    input  ln_vec_t   in_vec_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    // normalized output
    output ln_vec_t   out_vec_o,
    output logic      out_valid_o,
    input  logic      out_ready_i
);

    ln_affine_t  affine;
    logic        advance;
    // moment stage to isqrt stage
    ln_vec_t     mom_vec;
    ln_stats_t   mom_stats;
    logic        mom_valid;
    // isqrt stage to scale stage
    ln_cen_vec_t sq_cen;
    std_t        sq_std;
    logic        sq_valid;

    // input is taken whenever the pipeline moves
    assign in_ready_o = advance;

    ln_affine_regs u_affine_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .affine_o    (affine)
    );

    // stages 1 and 2
    ln_moment_stage u_moment (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .advance_i (advance),
        .vec_i     (in_vec_i),
        .valid_i   (in_valid_i),
        .vec_o     (mom_vec),
        .stats_o   (mom_stats),
        .valid_o   (mom_valid)
    );

    // stage 3
    ln_isqrt_stage u_isqrt (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .advance_i (advance),
        .vec_i     (mom_vec),
        .stats_i   (mom_stats),
        .valid_i   (mom_valid),
        .epsilon_i (affine.epsilon),
        .cen_o     (sq_cen),
        .std_o     (sq_std),
        .valid_o   (sq_valid)
    );

    // stage 4, owns the stall
    ln_scale_stage u_scale (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cen_i       (sq_cen),
        .std_i       (sq_std),
        .valid_i     (sq_valid),
        .affine_i    (affine),
        .out_ready_i (out_ready_i),
        .vec_o       (out_vec_o),
        .valid_o     (out_valid_o),
        .advance_o   (advance)
    );

endmodule

// ==== verification/ln_clk_gen.sv ====
`timescale 1ns/10ps

module ln_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 2;

    initial
    begin
        clk_o = 1'b0;
        forever
            #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // clean falling edge so the async reset fires before the first clock
    initial
    begin
        rst_n_o = 1'b1;
        #1;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== verification/ln_tb.sv ====
`timescale 1ns/10ps

module ln_tb
    import ln_pkg::*;
();

    // record kinds in the test data file
    localparam logic [7:0] REC_TEST   = 8'h01;
    localparam logic [7:0] REC_CFG    = 8'h02;
    localparam logic [7:0] REC_SAMPLE = 8'h03;
    localparam logic [7:0] REC_EXPECT = 8'h04;
    localparam logic [7:0] REC_END    = 8'hFF;
    localparam int MAX_RECS          = 256;
    localparam int LATENCY           = 4;
    // two reset cycles plus the first one after
    localparam int RESET_CHECKS      = 3;
    localparam int CYCLES_PER_SAMPLE = 40;
    localparam int WATCHDOG_SLACK    = 200;

    logic      clk;
    logic      rst_n;
    logic      cfg_we;
    reg_addr_t cfg_addr;
    elem_t     cfg_wdata;
    ln_vec_t   in_vec;
    logic      in_valid;
    logic      in_ready;
    ln_vec_t   out_vec;
    logic      out_valid;
    logic      out_ready;

    logic [71:0] recs [MAX_RECS];
    // stimulus of the current test
    reg_addr_t cfg_addr_q[$];
    elem_t     cfg_data_q[$];
    ln_vec_t   in_q[$];
    ln_vec_t   exp_q[$];
    // accepted samples still in the pipeline
    ln_vec_t   pend_q[$];
    int        accept_cyc_q[$];

    int   seed         = 6949;
    int   sample_count = 0;
    logic loaded       = 1'b0;
    int   tests_passed = 0;
    int   tests_failed = 0;

    ln_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ln_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .in_vec_i    (in_vec),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_vec_o   (out_vec),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    task automatic finish_test(input int id, input string what, input int errs);
        if (errs == 0)
        begin
            tests_passed++;
            $display("test %0d, %s: ok", id, what);
        end
        else
        begin
            tests_failed++;
            $display("test %0d, %s: %0d errors", id, what, errs);
        end
    endtask

    // lane by lane, reports every mismatch
    function automatic int compare_vec(input int id, input int num, input ln_vec_t got,
                                       input ln_vec_t exp);
        int errs;
        errs = 0;
        for (int i = 0; i < LN_DEPTH; i++)
        begin
            if (got.lane[i] !== exp.lane[i])
            begin
                $display("[ERROR] %0t: test %0d output %0d lane %0d got %0d expected %0d",
                         $time, id, num, i, got.lane[i], exp.lane[i]);
                errs++;
            end
        end
        return errs;
    endfunction

    // sampled on the edges while reset is held and one cycle after
    task automatic check_reset();
        int errs;
        errs = 0;
        repeat (RESET_CHECKS)
        begin
            @(posedge clk);
            if (out_valid !== 1'b0 || in_ready !== 1'b1)
            begin
                $display("[ERROR] %0t: reset state out_valid %b in_ready %b", $time,
                         out_valid, in_ready);
                errs++;
            end
        end
        out_ready <= 1'b1;
        finish_test(1, "reset state", errs);
    endtask

    task automatic run_test(input int id, input logic stall_mode);
        int      errs;
        int      cyc;
        int      got;
        int      lat;
        int      r;
        int      n;
        logic    held;
        ln_vec_t held_vec;
        ln_vec_t exp_vec;
        errs = 0;
        cyc  = 0;
        got  = 0;
        held = 1'b0;
        n    = in_q.size();
        // config writes go in while the pipeline is empty
        while (cfg_addr_q.size() > 0)
        begin
            @(posedge clk);
            cfg_we    <= 1'b1;
            cfg_addr  <= cfg_addr_q.pop_front();
            cfg_wdata <= cfg_data_q.pop_front();
        end
        @(posedge clk);
        cfg_we <= 1'b0;
        do
        begin
            @(posedge clk);
            cyc++;
            // values seen here are the ones before the edge
            if (held && (!out_valid || out_vec !== held_vec))
            begin
                $display("[ERROR] %0t: test %0d output changed while stalled", $time, id);
                errs++;
            end
            held     = out_valid && !out_ready;
            held_vec = out_vec;
            if (out_valid && out_ready)
            begin
                if (pend_q.size() == 0)
                begin
                    $display("[ERROR] %0t: test %0d output with no sample pending", $time, id);
                    errs++;
                end
                else
                begin
                    exp_vec = pend_q.pop_front();
                    lat     = cyc - accept_cyc_q.pop_front();
                    errs    = errs + compare_vec(id, got, out_vec, exp_vec);
                    // fixed latency only holds without stalls
                    if (!stall_mode && lat != LATENCY)
                    begin
                        $display("[ERROR] %0t: test %0d output %0d latency %0d expected %0d",
                                 $time, id, got, lat, LATENCY);
                        errs++;
                    end
                    got++;
                end
            end
            if (in_valid && in_ready)
            begin
                pend_q.push_back(exp_q.pop_front());
                accept_cyc_q.push_back(cyc);
                void'(in_q.pop_front());
            end
            // next cycle's inputs
            if (in_q.size() > 0)
            begin
                in_valid <= 1'b1;
                in_vec   <= in_q[0];
            end
            else
            begin
                in_valid <= 1'b0;
                in_vec   <= '0;
            end
            r = $random(seed);
            // ready three times out of four under stalls
            out_ready <= stall_mode ? (r[1:0] != 2'b00) : 1'b1;
        end
        while (in_q.size() > 0 || pend_q.size() > 0);
        out_ready <= 1'b1;
        // nothing may trail the last sample
        repeat (LATENCY + 2)
        begin
            @(posedge clk);
            if (out_valid)
            begin
                $display("[ERROR] %0t: test %0d extra output after the last sample", $time, id);
                errs++;
            end
        end
        finish_test(id, $sformatf("%0d samples, %s", n,
                    stall_mode ? "random out_ready" : "out_ready held"), errs);
    endtask

    initial
    begin
        int         idx;
        int         test_id;
        logic       stall_mode;
        logic       data_bad;
        logic [7:0] kind;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        in_vec    = '0;
        in_valid  = 1'b0;
        // output refused in reset so in_ready only follows the valid reset
        out_ready = 1'b0;
        data_bad  = 1'b0;
        $readmemh("verification/ln_testdata.mem", recs);
        for (int i = 0; i < MAX_RECS && recs[i][71:64] !== REC_END; i++)
        begin
            if (recs[i][71:64] == REC_SAMPLE)
                sample_count++;
        end
        loaded = 1'b1;
        check_reset();
        idx     = 0;
        test_id = 1;
        while (idx < MAX_RECS && recs[idx][71:64] == REC_TEST)
        begin
            test_id++;
            stall_mode = recs[idx][0];
            idx++;
            kind = recs[idx][71:64];
            while (idx < MAX_RECS && kind != REC_TEST && kind != REC_END)
            begin
                case (kind)
                    REC_CFG:
                    begin
                        cfg_addr_q.push_back(recs[idx][11:8]);
                        cfg_data_q.push_back(recs[idx][7:0]);
                    end
                    REC_SAMPLE: in_q.push_back(recs[idx][63:0]);
                    REC_EXPECT: exp_q.push_back(recs[idx][63:0]);
                    default:    data_bad = 1'b1;
                endcase
                idx++;
                kind = recs[idx][71:64];
            end
            // every sample needs exactly one expected vector
            if (in_q.size() != exp_q.size())
            begin
                data_bad = 1'b1;
                in_q.delete();
                exp_q.delete();
                cfg_addr_q.delete();
                cfg_data_q.delete();
            end
            else
            begin
                run_test(test_id, stall_mode);
            end
        end
        if (data_bad || idx >= MAX_RECS || recs[idx][71:64] !== REC_END)
        begin
            $display("test data file is malformed or has no end record");
            tests_failed++;
        end
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // bound on the whole run, from the number of samples in the file
    initial
    begin
        wait (loaded);
        repeat (sample_count * CYCLES_PER_SAMPLE + WATCHDOG_SLACK) @(posedge clk);
        $display("watchdog expired: outputs stopped arriving, %0d samples were expected",
                 sample_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verification/ln_testdata.mem ====
// each line: kind (2 hex digits) then a 64-bit payload, vectors lane 7 first
// 01 test start (payload 0 out_ready held, 1 random), 02 config (addr [11:8] data [7:0]), 03 sample, 04 expected, FF end
// identity after reset, back to back, includes a constant sample
010000000000000000
030000F808E020F010
040000F907E41CF20E
032525252525252525
040000000000000000
034000000000000000
042AFAFAFAFAFAFAFA
0304FF0BEC0702FBFD
040A0018DA1006F8FC
038878E719CE329C64
04E917FC04F709ED13
// identity again under random stalls
010000000000000001
0304FF0BEC0702FBFD
040A0018DA1006F8FC
038878E719CE329C64
04E917FC04F709ED13
030000F808E020F010
040000F907E41CF20E
034000000000000000
042AFAFAFAFAFAFAFA
032525252525252525
040000000000000000
038878E719CE329C64
04E917FC04F709ED13
030000F808E020F010
040000F907E41CF20E
// gamma lanes 1..6, beta lanes 1,2,3,5,6, epsilon 36, then enable
010000000000000000
020000000000000120
0200000000000002F0
020000000000000340
020000000000000408
02000000000000057F
020000000000000680
020000000000000910
020000000000000AE0
020000000000000B05
020000000000000DFF
020000000000000E03
020000000000000F24
020000000000000F01
030000F808E020F010
040003CF039DC6F60D
030000000040000000
04FB2BD7FD7FE506FB
0300300000D0000000
040080FF0085E01000
032525252525252525
040003FF0005E01000
// same affine setup under random stalls
010000000000000001
030000000040000000
04FB2BD7FD7FE506FB
0300300000D0000000
040080FF0085E01000
030000F808E020F010
040003CF039DC6F60D
032525252525252525
040003FF0005E01000
FF0000000000000000

// ==== sim.f ====
src/ln_pkg.sv
src/ln_affine_regs.sv
src/ln_moment_stage.sv
src/ln_isqrt_stage.sv
src/ln_scale_stage.sv
src/ln_top.sv
verification/ln_clk_gen.sv
verification/ln_tb.sv

// ==== Makefile ====
# Verilator build and run for the layer-norm testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module ln_tb -Mdir obj_dir

# exit status comes from the search for the pass line
run: compile
	@out=$$(./obj_dir/Vln_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
